// File: source/exec_defs.svh
// Execute pipeline widths
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Operand, result and bus data word
`define EXEC_DATA_W 64

// Data bus byte address
`define EXEC_ADDR_W 32

// Register id, 32 GPRs with R0 as zero register
`define EXEC_RID_W 5

// Longest sleep hold in cycles, fits the 4-bit count
`define EXEC_SLEEP_MAX 15

`endif

// File: source/execUopPkg.sv
// Micro-op command types
`default_nettype none

`include "exec_defs.svh"

package execUopPkg;

	// Command set of the execute pipeline
	typedef enum logic [3:0] {
		cmdNop   = 4'h0,
		cmdAdd   = 4'h1,	// Rs + Rt
		cmdSub   = 4'h2,	// Rs - Rt
		cmdAnd   = 4'h3,
		cmdOr    = 4'h4,
		cmdXor   = 4'h5,
		cmdCmpEq = 4'h6,	// T only
		cmdCmpGt = 4'h7,	// T only, signed
		cmdMovi  = 4'h8,	// Imm to Rn
		cmdLoad  = 4'h9,	// Rn = mem[Rs + Imm]
		cmdStore = 4'hA,	// mem[Rs + Imm] = Rm
		cmdSleep = 4'hB	// Hold for Imm[3:0] cycles
	} uopCmd_t;

	// Id 0 reads as zero, writes dropped
	typedef logic [`EXEC_RID_W-1:0] regId_t;

endpackage

`default_nettype wire

// File: source/execMemPkg.sv
// Memory access and stage payload types
`default_nettype none

`include "exec_defs.svh"

package execMemPkg;
	import execUopPkg::*;

	typedef enum logic [1:0] {memNone, memRead, memWrite} memKind_t;

	// AXI BRESP / RRESP encoding
	typedef enum logic [1:0] {respOkay, respExOkay, respSlvErr, respDecErr} axiResp_t;

	// EX1 result as latched into EX2
	typedef struct packed {
		uopCmd_t                 cmd;
		regId_t                  rn;		// Destination
		logic [`EXEC_DATA_W-1:0] result;	// ALU or MOVI value
		logic                    tVal;
		logic                    tValid;	// Compare op, updates T
		memKind_t                memKind;
		logic [`EXEC_ADDR_W-1:0] memAddr;
		logic [`EXEC_DATA_W-1:0] memWdata;
		logic [3:0]              sleepCnt;	// Already capped
	} ex1Out_t;

endpackage

`default_nettype wire

// File: source/stageReg.sv
// Pipeline stage register
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clock,
	input  logic     rst,
	input  logic     hold,
	input  logic     flush,
	input  logic     inValid,
	input  payload_t inData,
	output logic     outValid,
	output payload_t outData
);

	// Valid bit, flush wins over hold
	always_ff @(posedge clock) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (flush) begin
			outValid <= 1'b0;	// Bubble
		end else if (!hold) begin
			outValid <= inValid;
		end
	end

	// Payload kept during hold, so a flushed op still shows its fields
	always_ff @(posedge clock) begin
		if (!hold) begin
			outData <= inData;
		end
	end

endmodule

`default_nettype wire

// File: source/exStage1.sv
// EX1 ALU, compare and address stage
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module exStage1
	import execUopPkg::*;
	import execMemPkg::*;
(
	input  logic                    valid,
	input  uopCmd_t                 cmd,
	input  regId_t                  rn,
	input  logic [`EXEC_DATA_W-1:0] rsVal,
	input  logic [`EXEC_DATA_W-1:0] rtVal,
	input  logic [`EXEC_DATA_W-1:0] rmVal,
	input  logic [`EXEC_DATA_W-1:0] imm,
	output ex1Out_t                 ex1
);

	logic [3:0] sleepReq;	// Raw count from immediate

	assign sleepReq = imm[3:0];

	always_comb begin
		ex1          = '0;
		ex1.cmd      = valid ? cmd : cmdNop;	// Bubble decodes as NOP
		ex1.rn       = rn;
		ex1.memAddr  = rsVal[`EXEC_ADDR_W-1:0] + imm[`EXEC_ADDR_W-1:0];
		ex1.memWdata = rmVal;	// Store data

		case (ex1.cmd)
			cmdAdd: ex1.result = rsVal + rtVal;
			cmdSub: ex1.result = rsVal - rtVal;
			cmdAnd: ex1.result = rsVal & rtVal;
			cmdOr:  ex1.result = rsVal | rtVal;
			cmdXor: ex1.result = rsVal ^ rtVal;
			cmdMovi: ex1.result = imm;
			cmdCmpEq: begin
				ex1.tVal   = (rsVal == rtVal);
				ex1.tValid = 1'b1;
			end
			cmdCmpGt: begin
				// Signed compare
				ex1.tVal   = ($signed(rsVal) > $signed(rtVal));
				ex1.tValid = 1'b1;
			end
			cmdLoad:  ex1.memKind = memRead;
			cmdStore: ex1.memKind = memWrite;
			cmdSleep: begin
				if (sleepReq > 4'(`EXEC_SLEEP_MAX))
					ex1.sleepCnt = 4'(`EXEC_SLEEP_MAX);	// Cap
				else
					ex1.sleepCnt = sleepReq;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/exStage2.sv
// EX2 control and writeback stage
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module exStage2
	import execUopPkg::*;
	import execMemPkg::*;
(
	input  logic                    clock,
	input  logic                    rst,
	input  logic                    valid,
	input  ex1Out_t                 ex1,
	input  logic                    flush,
	input  logic                    memDone,
	input  logic [`EXEC_DATA_W-1:0] memRdata,
	output logic                    memStart,
	output memKind_t                memKind,
	output logic [`EXEC_ADDR_W-1:0] memAddr,
	output logic [`EXEC_DATA_W-1:0] memWdata,
	output logic                    exHold,
	output logic                    wbValid,
	output regId_t                  wbId,
	output logic [`EXEC_DATA_W-1:0] wbValue,
	output logic                    srT
);

	typedef enum logic [1:0] {stIdle, stMemWait, stSleep} ex2State_t;

	ex2State_t  state;
	logic [3:0] sleepCnt;	// Cycles held so far
	logic       live;		// Op in EX2 may act this cycle
	logic       writesRn;
	logic       sleepStart;
	logic       sleepHold;

	// Flushed or already started ops do not act again
	assign live = valid && !flush && (state == stIdle);

	always_comb begin
		case (ex1.cmd)
			cmdAdd, cmdSub, cmdAnd, cmdOr, cmdXor, cmdMovi: writesRn = 1'b1;
			default: writesRn = 1'b0;
		endcase
	end

	// Request fields straight from the EX2 payload
	assign memKind  = ex1.memKind;
	assign memAddr  = ex1.memAddr;
	assign memWdata = ex1.memWdata;
	assign memStart = live && (ex1.memKind != memNone);	// Only from idle, once per op

	assign sleepStart = live && (ex1.cmd == cmdSleep) && (ex1.sleepCnt != 4'd0);
	assign sleepHold  = (state == stSleep) && (sleepCnt < ex1.sleepCnt);

	// Hold drops in the memDone cycle so the op leaves at the next edge
	assign exHold = memStart || sleepStart || sleepHold ||
		((state == stMemWait) && !memDone);

	always_ff @(posedge clock) begin
		if (rst) begin
			state    <= stIdle;
			sleepCnt <= 4'd0;
			wbValid  <= 1'b0;
			srT      <= 1'b0;
		end else begin
			wbValid <= 1'b0;	// One-cycle pulse
			case (state)
				stIdle: begin
					if (memStart) begin
						state <= stMemWait;
					end else if (sleepStart) begin
						state    <= stSleep;
						sleepCnt <= 4'd1;	// First held cycle counted here
					end else if (live) begin
						wbValid <= writesRn && (ex1.rn != '0);	// R0 dropped
						if (ex1.tValid)
							srT <= ex1.tVal;
					end
				end
				stMemWait: begin
					if (memDone) begin
						state   <= stIdle;
						wbValid <= (ex1.memKind == memRead) && (ex1.rn != '0);
					end
				end
				stSleep: begin
					// Saturating count
					sleepCnt <= sleepCnt + 4'(sleepCnt != 4'(`EXEC_SLEEP_MAX));
					if (!sleepHold)
						state <= stIdle;	// Sleep op retires
				end
				default: state <= stIdle;
			endcase
		end
	end

	// Writeback payload, load data only on the memDone edge
	always_ff @(posedge clock) begin
		wbId    <= ex1.rn;
		wbValue <= (state == stMemWait) ? memRdata : ex1.result;
	end

endmodule

`default_nettype wire

// File: source/memAxiPort.sv
// AXI4-Lite data bus master
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module memAxiPort
	import execMemPkg::*;
(
	input  logic                      clock,
	input  logic                      rst,
	input  logic                      memStart,
	input  memKind_t                  memKind,
	input  logic [`EXEC_ADDR_W-1:0]   memAddr,
	input  logic [`EXEC_DATA_W-1:0]   memWdata,
	output logic                      memDone,
	output logic [`EXEC_DATA_W-1:0]   memRdata,
	output logic [`EXEC_ADDR_W-1:0]   axiAwaddr,
	output logic                      axiAwvalid,
	input  logic                      axiAwready,
	output logic [`EXEC_DATA_W-1:0]   axiWdata,
	output logic [`EXEC_DATA_W/8-1:0] axiWstrb,
	output logic                      axiWvalid,
	input  logic                      axiWready,
	input  logic                      axiBvalid,
	input  axiResp_t                  axiBresp,
	output logic                      axiBready,
	output logic [`EXEC_ADDR_W-1:0]   axiAraddr,
	output logic                      axiArvalid,
	input  logic                      axiArready,
	input  logic                      axiRvalid,
	input  logic [`EXEC_DATA_W-1:0]   axiRdata,
	input  axiResp_t                  axiRresp,
	output logic                      axiRready
);

	typedef enum logic [1:0] {axIdle, axWrite, axRead} axState_t;

	axState_t state;
	axiResp_t lastResp;	// Response of the last access

	assign axiWstrb  = '1;	// Full word accesses only
	assign axiBready = (state == axWrite);
	assign axiRready = (state == axRead);

	always_ff @(posedge clock) begin
		if (rst) begin
			state      <= axIdle;
			axiAwvalid <= 1'b0;
			axiWvalid  <= 1'b0;
			axiArvalid <= 1'b0;
			memDone    <= 1'b0;
		end else begin
			memDone <= 1'b0;
			case (state)
				axIdle: begin
					if (memStart && (memKind == memWrite)) begin
						state      <= axWrite;
						axiAwvalid <= 1'b1;	// AW and W together
						axiWvalid  <= 1'b1;
					end else if (memStart && (memKind == memRead)) begin
						state      <= axRead;
						axiArvalid <= 1'b1;
					end
				end
				axWrite: begin
					// Each channel drops on its own handshake
					if (axiAwready)
						axiAwvalid <= 1'b0;
					if (axiWready)
						axiWvalid <= 1'b0;
					if (axiBvalid) begin
						state   <= axIdle;
						memDone <= 1'b1;
					end
				end
				axRead: begin
					if (axiArready)
						axiArvalid <= 1'b0;
					if (axiRvalid) begin
						state   <= axIdle;
						memDone <= 1'b1;
					end
				end
				default: state <= axIdle;
			endcase
		end
	end

	// Request and response payload
	always_ff @(posedge clock) begin
		if (memStart && (state == axIdle)) begin
			axiAwaddr <= memAddr;
			axiAraddr <= memAddr;
			axiWdata  <= memWdata;
		end
		if (axiRvalid && axiRready) begin
			memRdata <= axiRdata;
			lastResp <= axiRresp;
		end else if (axiBvalid && axiBready) begin
			lastResp <= axiBresp;
		end
	end

endmodule

`default_nettype wire

// File: source/execTop.sv
// Execute pipeline top level
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module execTop
	import execUopPkg::*;
	import execMemPkg::*;
(
	input  logic                      clock,
	input  logic                      rst,
	input  logic                      issueValid,
	input  uopCmd_t                   issueCmd,
	input  regId_t                    issueRn,
	input  logic [`EXEC_DATA_W-1:0]   issueRsVal,
	input  logic [`EXEC_DATA_W-1:0]   issueRtVal,
	input  logic [`EXEC_DATA_W-1:0]   issueRmVal,
	input  logic [`EXEC_DATA_W-1:0]   issueImm,
	input  logic                      flush,
	output logic                      exHold,
	output logic                      wbValid,
	output regId_t                    wbId,
	output logic [`EXEC_DATA_W-1:0]   wbValue,
	output logic                      srT,
	output logic [`EXEC_ADDR_W-1:0]   axiAwaddr,
	output logic                      axiAwvalid,
	input  logic                      axiAwready,
	output logic [`EXEC_DATA_W-1:0]   axiWdata,
	output logic [`EXEC_DATA_W/8-1:0] axiWstrb,
	output logic                      axiWvalid,
	input  logic                      axiWready,
	input  logic                      axiBvalid,
	input  axiResp_t                  axiBresp,
	output logic                      axiBready,
	output logic [`EXEC_ADDR_W-1:0]   axiAraddr,
	output logic                      axiArvalid,
	input  logic                      axiArready,
	input  logic                      axiRvalid,
	input  logic [`EXEC_DATA_W-1:0]   axiRdata,
	input  axiResp_t                  axiRresp,
	output logic                      axiRready
);

	// Issued op as held in EX1
	typedef struct packed {
		uopCmd_t                 cmd;
		regId_t                  rn;
		logic [`EXEC_DATA_W-1:0] rsVal;
		logic [`EXEC_DATA_W-1:0] rtVal;
		logic [`EXEC_DATA_W-1:0] rmVal;
		logic [`EXEC_DATA_W-1:0] imm;
	} issuePayload_t;

	issuePayload_t                 issueIn;
	issuePayload_t                 ex1Op;
	logic                          ex1Valid;
	ex1Out_t                       ex1Res;
	ex1Out_t                       ex2Op;
	logic                          ex2Valid;
	logic                          memStart;
	memKind_t                      memKind;
	logic [`EXEC_ADDR_W-1:0]       memAddr;
	logic [`EXEC_DATA_W-1:0]       memWdata;
	logic                          memDone;
	logic [`EXEC_DATA_W-1:0]       memRdata;

	assign issueIn = '{cmd: issueCmd, rn: issueRn, rsVal: issueRsVal,
		rtVal: issueRtVal, rmVal: issueRmVal, imm: issueImm};

	// Op issued alongside a flush is kept
	stageReg #(.payload_t(issuePayload_t)) issueReg (
		.clock(clock), .rst(rst), .hold(exHold), .flush(1'b0),
		.inValid(issueValid), .inData(issueIn),
		.outValid(ex1Valid), .outData(ex1Op)
	);

	exStage1 ex1 (
		.valid(ex1Valid), .cmd(ex1Op.cmd), .rn(ex1Op.rn),
		.rsVal(ex1Op.rsVal), .rtVal(ex1Op.rtVal), .rmVal(ex1Op.rmVal),
		.imm(ex1Op.imm), .ex1(ex1Res)
	);

	// Flush turns the EX1 op into a bubble on its way to EX2
	stageReg #(.payload_t(ex1Out_t)) ex2Reg (
		.clock(clock), .rst(rst), .hold(exHold), .flush(flush),
		.inValid(ex1Valid), .inData(ex1Res),
		.outValid(ex2Valid), .outData(ex2Op)
	);

	exStage2 ex2 (
		.clock(clock), .rst(rst), .valid(ex2Valid), .ex1(ex2Op), .flush(flush),
		.memDone(memDone), .memRdata(memRdata), .memStart(memStart),
		.memKind(memKind), .memAddr(memAddr), .memWdata(memWdata),
		.exHold(exHold), .wbValid(wbValid), .wbId(wbId), .wbValue(wbValue),
		.srT(srT)
	);

	memAxiPort busPort (
		.clock(clock), .rst(rst), .memStart(memStart), .memKind(memKind),
		.memAddr(memAddr), .memWdata(memWdata), .memDone(memDone),
		.memRdata(memRdata),
		.axiAwaddr(axiAwaddr), .axiAwvalid(axiAwvalid), .axiAwready(axiAwready),
		.axiWdata(axiWdata), .axiWstrb(axiWstrb), .axiWvalid(axiWvalid),
		.axiWready(axiWready), .axiBvalid(axiBvalid), .axiBresp(axiBresp),
		.axiBready(axiBready), .axiAraddr(axiAraddr), .axiArvalid(axiArvalid),
		.axiArready(axiArready), .axiRvalid(axiRvalid), .axiRdata(axiRdata),
		.axiRresp(axiRresp), .axiRready(axiRready)
	);

endmodule

`default_nettype wire

// File: testbench/execTop_assertions.sv
// Execute pipeline protocol checks
`timescale 1ns/1ps
`default_nettype none

module execTop_assertions
	import execMemPkg::*;
(
	input wire logic        clock,
	input wire logic        rst,
	input wire logic        exHold,
	input wire logic        wbValid,
	input wire logic        memStart,
	input wire logic        axiAwvalid,
	input wire logic        axiAwready,
	input wire logic [31:0] axiAwaddr,
	input wire logic        axiWvalid,
	input wire logic        axiWready,
	input wire logic [63:0] axiWdata,
	input wire logic        axiArvalid,
	input wire logic        axiArready,
	input wire logic [31:0] axiAraddr,
	input wire logic        axiBvalid,
	input wire logic        axiBready,
	input wire logic        axiRvalid,
	input wire logic        axiRready,
	input wire axiResp_t    lastResp
);

	int assertFails = 0;	// Failed assertions so far

	// Valid and payload held until the handshake
	awStable: assert property (@(posedge clock) disable iff (rst)
		axiAwvalid && !axiAwready |=> axiAwvalid && $stable(axiAwaddr))
		else begin
			assertFails++;
			$error("AW channel changed before AWREADY");
		end
	wStable: assert property (@(posedge clock) disable iff (rst)
		axiWvalid && !axiWready |=> axiWvalid && $stable(axiWdata))
		else begin
			assertFails++;
			$error("W channel changed before WREADY");
		end
	arStable: assert property (@(posedge clock) disable iff (rst)
		axiArvalid && !axiArready |=> axiArvalid && $stable(axiAraddr))
		else begin
			assertFails++;
			$error("AR channel changed before ARREADY");
		end

	// A held cycle never retires anything
	noWbInHold: assert property (@(posedge clock) disable iff (rst)
		exHold |=> !wbValid)
		else begin
			assertFails++;
			$error("Writeback right after a held cycle");
		end
	noStartInHold: assert property (@(posedge clock) disable iff (rst)
		exHold |=> !memStart)
		else begin
			assertFails++;
			$error("Second memory request during a hold");
		end

	// Bus errors are not modeled so every captured response is OKAY
	okayResp: assert property (@(posedge clock) disable iff (rst)
		(axiBvalid && axiBready) || (axiRvalid && axiRready) |=> lastResp == respOkay)
		else begin
			assertFails++;
			$error("Captured bus response is not OKAY");
		end

endmodule

// Top level carries both the EX2 control and the bus port signals
bind execTop execTop_assertions chk (
	.clock(clock), .rst(rst), .exHold(exHold), .wbValid(wbValid),
	.memStart(memStart), .axiAwvalid(axiAwvalid), .axiAwready(axiAwready),
	.axiAwaddr(axiAwaddr), .axiWvalid(axiWvalid), .axiWready(axiWready),
	.axiWdata(axiWdata), .axiArvalid(axiArvalid), .axiArready(axiArready),
	.axiAraddr(axiAraddr), .axiBvalid(axiBvalid), .axiBready(axiBready),
	.axiRvalid(axiRvalid), .axiRready(axiRready), .lastResp(busPort.lastResp)
);

`default_nettype wire

// File: testbench/execTop_tb.sv
// Execute pipeline testbench
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module execTop_tb
	import execUopPkg::*;
	import execMemPkg::*;
;

	logic clock, rst, issueValid, flush;
	uopCmd_t issueCmd;
	regId_t issueRn;
	logic [`EXEC_DATA_W-1:0] issueRsVal, issueRtVal, issueRmVal, issueImm;
	logic exHold, wbValid, srT;
	regId_t wbId;
	logic [`EXEC_DATA_W-1:0] wbValue;
	logic [`EXEC_ADDR_W-1:0] axiAwaddr, axiAraddr;
	logic [`EXEC_DATA_W-1:0] axiWdata, axiRdata;
	logic [`EXEC_DATA_W/8-1:0] axiWstrb;
	logic axiAwvalid, axiAwready, axiWvalid, axiWready, axiBvalid, axiBready;
	logic axiArvalid, axiArready, axiRvalid, axiRready;
	axiResp_t axiBresp, axiRresp;

	logic [`EXEC_DATA_W-1:0] mem [64];	// Slave memory with one word per 8 bytes
	logic [31:0] lfsr = 32'h0115_da44;
	int errors = 0;
	int checks = 0;
	int writeCount = 0;	// AW/W accepted by the model
	int respCount = 0;	// B or R responses given

	execTop uut (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		#500000;	// Whole-run watchdog
		$display("Simulation stopped at time limit, pipeline hung");
		$display("*** TEST FAILED ***");
		$finish;
	end

	// Galois LFSR stepped once per bit
	function automatic logic [63:0] randBits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r = {r[62:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic checkWord(input string name, input logic [`EXEC_DATA_W-1:0] got,
			input logic [`EXEC_DATA_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkId(input string name, input regId_t got, input regId_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	// AXI slave with 0 to 3 cycle delays
	task automatic serveWrite();
		int idx;
		logic [`EXEC_DATA_W-1:0] data;
		logic [`EXEC_DATA_W/8-1:0] strb;
		idx = axiAwaddr[8:3];
		data = axiWdata;
		strb = axiWstrb;
		repeat (randBits(2)) @(posedge clock);
		@(posedge clock) #1;
		axiAwready = 1'b1;
		axiWready = 1'b1;
		@(posedge clock) #1;
		axiAwready = 1'b0;
		axiWready = 1'b0;
		for (int b = 0; b < `EXEC_DATA_W/8; b++) begin
			if (strb[b])
				mem[idx][8*b +: 8] = data[8*b +: 8];	// Only enabled byte lanes
		end
		writeCount++;
		repeat (randBits(2)) @(posedge clock);
		#1 axiBvalid = 1'b1;
		@(negedge clock);
		checkFlag("axiBready", axiBready, 1'b1);	// Port waits for B
		@(posedge clock) #1;
		axiBvalid = 1'b0;
		respCount++;
	endtask

	task automatic serveRead();
		int idx;
		idx = axiAraddr[8:3];
		repeat (randBits(2)) @(posedge clock);
		@(posedge clock) #1;
		axiArready = 1'b1;
		@(posedge clock) #1;
		axiArready = 1'b0;
		repeat (randBits(2)) @(posedge clock);
		#1;
		axiRvalid = 1'b1;
		axiRdata = mem[idx];
		@(negedge clock);
		checkFlag("axiRready", axiRready, 1'b1);	// Port waits for R
		@(posedge clock) #1;
		axiRvalid = 1'b0;
		respCount++;
	endtask

	initial begin
		forever begin
			@(negedge clock);
			if (!rst && axiAwvalid && axiWvalid)
				serveWrite();
			else if (!rst && axiArvalid)
				serveRead();
		end
	end

	// Drive one op and count held cycles until acceptance
	task automatic issueOp(input uopCmd_t cmd, input regId_t rn,
			input logic [63:0] rs, input logic [63:0] rt, input logic [63:0] rm,
			input logic [63:0] imm, output int stalls);
		logic done;
		done = 1'b0;
		stalls = 0;
		issueValid = 1'b1;
		issueCmd = cmd;
		issueRn = rn;
		issueRsVal = rs;
		issueRtVal = rt;
		issueRmVal = rm;
		issueImm = imm;
		for (int t = 0; t < 100 && !done; t++) begin
			@(negedge clock);
			if (!exHold)
				done = 1'b1;
			else
				stalls++;
			@(posedge clock) #1;
		end
		issueValid = 1'b0;
		issueCmd = cmdNop;
		if (!done) begin
			errors++;
			$display("Op with command %0d was never accepted", cmd);
		end
	endtask

	task automatic waitWb(output regId_t id, output logic [63:0] value);
		logic seen;
		seen = 1'b0;
		for (int t = 0; t < 100 && !seen; t++) begin
			@(negedge clock);
			if (wbValid) begin
				seen = 1'b1;
				id = wbId;
				value = wbValue;
			end
		end
		if (!seen) begin
			errors++;
			$display("No writeback arrived within 100 cycles");
		end
	endtask

	// Nothing may retire or go out on the bus
	task automatic expectQuiet(input int cycles);
		for (int t = 0; t < cycles; t++) begin
			@(negedge clock);
			checks++;
			if (wbValid || axiAwvalid || axiArvalid) begin
				errors++;
				$display("Unexpected writeback or bus request in a quiet window");
			end
		end
	endtask

	task automatic waitHoldRelease();
		int startResp;
		logic sawHold, done;
		startResp = respCount;
		sawHold = 1'b0;
		done = 1'b0;
		for (int t = 0; t < 100 && !done; t++) begin
			@(negedge clock);
			if (exHold)
				sawHold = 1'b1;
			else if (sawHold)
				done = 1'b1;
		end
		if (!done) begin
			errors++;
			$display("Memory hold never rose and fell");
		end else if (respCount == startResp) begin
			errors++;
			$display("Hold dropped before the bus response");
		end
	endtask

	task automatic resetOutputs();
		@(negedge clock);
		checkFlag("exHold", exHold, 1'b0);
		checkFlag("wbValid", wbValid, 1'b0);
		checkFlag("srT", srT, 1'b0);
		checkFlag("axiAwvalid", axiAwvalid, 1'b0);
		checkFlag("axiWvalid", axiWvalid, 1'b0);
		checkFlag("axiArvalid", axiArvalid, 1'b0);
		checkFlag("axiBready", axiBready, 1'b0);
		checkFlag("axiRready", axiRready, 1'b0);
		@(posedge clock) #1;
	endtask

	task automatic aluOps();
		uopCmd_t ops [6];
		logic [63:0] rs, rt, imm, exp;
		int stalls;
		ops = '{cmdAdd, cmdSub, cmdAnd, cmdOr, cmdXor, cmdMovi};
		for (int i = 0; i < 6; i++) begin
			rs = randBits(64);
			rt = randBits(64);
			imm = randBits(64);
			case (ops[i])
				cmdAdd: exp = rs + rt;
				cmdSub: exp = rs - rt;
				cmdAnd: exp = rs & rt;
				cmdOr: exp = rs | rt;
				cmdXor: exp = rs ^ rt;
				default: exp = imm;	// MOVI
			endcase
			issueOp(ops[i], regId_t'(i + 1), rs, rt, '0, imm, stalls);
			@(negedge clock);
			checkFlag("wbValid", wbValid, 1'b0);
			@(negedge clock);
			checkFlag("wbValid", wbValid, 1'b0);
			@(negedge clock);	// Two edges after acceptance
			checkFlag("wbValid", wbValid, 1'b1);
			checkId("wbId", wbId, regId_t'(i + 1));
			checkWord("wbValue", wbValue, exp);
			@(posedge clock) #1;
		end
		issueOp(cmdAdd, '0, 64'd7, 64'd9, '0, '0, stalls);	// R0 dropped
		expectQuiet(5);
	endtask

	task automatic compareOp(input uopCmd_t cmd, input logic [63:0] rs,
			input logic [63:0] rt);
		logic exp;
		int stalls;
		exp = (cmd == cmdCmpEq) ? (rs == rt) : ($signed(rs) > $signed(rt));
		issueOp(cmd, regId_t'(3), rs, rt, '0, '0, stalls);
		expectQuiet(4);
		checkFlag("srT", srT, exp);
		@(posedge clock) #1;
	endtask

	task automatic storeThenLoad(input logic [63:0] base, input logic [63:0] offs);
		logic [63:0] data, value;
		regId_t id;
		int idx, stalls;
		data = randBits(64);
		idx = (base[31:0] + offs[31:0]) >> 3;
		idx = idx % 64;
		issueOp(cmdStore, '0, base, '0, data, offs, stalls);
		waitHoldRelease();
		checkWord("mem", mem[idx], data);
		@(posedge clock) #1;
		issueOp(cmdLoad, regId_t'(9), base, '0, '0, offs, stalls);
		waitWb(id, value);
		checkId("wbId", id, regId_t'(9));
		checkWord("wbValue", value, data);
		@(posedge clock) #1;
	endtask

	task automatic sleepThenOps(input logic [63:0] imm);
		int stalls, k;
		regId_t id;
		logic [63:0] value;
		k = (imm[3:0] > `EXEC_SLEEP_MAX) ? `EXEC_SLEEP_MAX : imm[3:0];
		issueOp(cmdSleep, '0, '0, '0, '0, imm, stalls);
		issueOp(cmdAdd, regId_t'(5), 64'd40, 64'd2, '0, '0, stalls);	// Enters behind it
		issueOp(cmdMovi, regId_t'(6), '0, '0, '0, 64'h1234, stalls);	// Stalls during sleep
		checkWord("sleep hold cycles", 64'(stalls), 64'(k));
		waitWb(id, value);
		checkId("wbId", id, regId_t'(5));
		checkWord("wbValue", value, 64'd42);
		waitWb(id, value);
		checkId("wbId", id, regId_t'(6));
		checkWord("wbValue", value, 64'h1234);
		@(posedge clock) #1;
	endtask

	// Flush while the op sits in EX2
	task automatic flushInEx2(input uopCmd_t cmd, input logic [63:0] rs,
			input logic [63:0] rt, input logic [63:0] offs);
		logic oldT;
		logic [63:0] oldWord;
		int oldWrites, idx, stalls;
		oldT = srT;
		oldWrites = writeCount;
		idx = ((rs[31:0] + offs[31:0]) >> 3) % 64;
		oldWord = mem[idx];
		issueOp(cmd, regId_t'(7), rs, rt, randBits(64), offs, stalls);
		@(posedge clock) #1;
		flush = 1'b1;
		@(posedge clock) #1;
		flush = 1'b0;
		expectQuiet(8);
		checkFlag("srT", srT, oldT);
		checkWord("writeCount", 64'(writeCount), 64'(oldWrites));
		checkWord("mem", mem[idx], oldWord);
		@(posedge clock) #1;
	endtask

	initial begin
		for (int i = 0; i < 64; i++)
			mem[i] = {32'hA5A5_0000 ^ i, i * 32'h9E37_79B9};	// Whole-index fill
		rst = 1'b1;
		issueValid = 1'b0;
		issueCmd = cmdNop;
		issueRn = '0;
		issueRsVal = '0;
		issueRtVal = '0;
		issueRmVal = '0;
		issueImm = '0;
		flush = 1'b0;
		axiAwready = 1'b0;
		axiWready = 1'b0;
		axiBvalid = 1'b0;
		axiBresp = respOkay;
		axiArready = 1'b0;
		axiRvalid = 1'b0;
		axiRdata = '0;
		axiRresp = respOkay;
		repeat (8) @(posedge clock);
		#1 rst = 1'b0;

		resetOutputs();
		aluOps();
		compareOp(cmdCmpEq, 64'h55, 64'h55);
		compareOp(cmdCmpGt, 64'hFFFF_FFFF_FFFF_FFF0, 64'd5);	// Negative so not greater
		compareOp(cmdCmpGt, 64'd5, 64'hFFFF_FFFF_FFFF_FFF0);
		compareOp(cmdCmpEq, 64'h55, 64'h56);
		storeThenLoad(64'h100, 64'h28);
		storeThenLoad(64'h40, 64'h1F8);
		sleepThenOps(64'h3);
		sleepThenOps(64'h3F);	// Low bits give 15 which is the cap
		compareOp(cmdCmpEq, 64'h1, 64'h1);	// T set before the flush test
		flushInEx2(cmdCmpEq, 64'h2, 64'h3, '0);
		flushInEx2(cmdAdd, 64'h2, 64'h3, '0);
		flushInEx2(cmdStore, 64'h80, '0, 64'h10);

		errors += uut.chk.assertFails;
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+source
source/execUopPkg.sv
source/execMemPkg.sv
source/stageReg.sv
source/exStage1.sv
source/exStage2.sv
source/memAxiPort.sv
source/execTop.sv
testbench/execTop_assertions.sv
testbench/execTop_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execute pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module execTop_tb -f list.f -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
	exit 0
fi
exit 1
